/* design/rv_core_params.svh */
//////////////////////////////////////////////////////////////////////
// Core-wide constants
// Word width, register file size and fetch depth
//////////////////////////////////////////////////////////////////////

`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Data and address width
`define RV_XLEN        32

// Architectural registers, x0 included
`define RV_NUM_REGS    32
`define RV_REG_AW      5

// Max fetch requests in flight
`define RV_FETCH_DEPTH 2

`endif

/* design/rv_core_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared types of the core
// Opcode and ALU enums, bus structs, pipeline structs
//////////////////////////////////////////////////////////////////////

`include "rv_core_params.svh"

package rv_core_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_OPIMM  = 7'b0010011,
    OP_OP     = 7'b0110011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASSB    // LUI, operand b goes straight out
  } alu_op_e;

  // Request side of instr and data bus
  typedef struct packed {
    logic                req;
    logic                we;
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                gnt;
    logic                rvalid;
    logic [`RV_XLEN-1:0] rdata;
  } mem_rsp_t;

  // IF -> ID-EX
  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    logic [31:0]         instr;
  } fetch_t;

  // ID-EX -> IF, taken branch or jump
  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] target;
  } redirect_t;

  // ID-EX -> LSU, word access only
  typedef struct packed {
    logic                valid;
    logic                we;
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
  } lsu_cmd_t;

endpackage

/* design/rv_if_stage.sv */
//////////////////////////////////////////////////////////////////////
// Instruction fetch stage
// Fetch PC, bus request, prefetch buffer, redirect flush
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "rv_core_params.svh"

module rv_if_stage (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  logic                   fetch_enable_i,
  input  logic [`RV_XLEN-1:0]    boot_addr_i,
  input  rv_core_pkg::mem_rsp_t  instr_rsp_i,
  input  rv_core_pkg::redirect_t redirect_i,
  input  logic                   id_ready_i,
  output rv_core_pkg::mem_req_t  instr_req_o,
  output rv_core_pkg::fetch_t    fetch_o
);

  localparam int unsigned CNT_W = $clog2(`RV_FETCH_DEPTH + 1);
  localparam int unsigned PTR_W = $clog2(`RV_FETCH_DEPTH);

  logic                en_q;       // Fetch enable seen since reset
  logic [`RV_XLEN-1:0] pc_q;       // Address of next request
  logic [`RV_XLEN-1:0] rsp_pc_q;   // PC of next live response
  logic                pend_q;     // Redirect parked behind a held request
  logic [`RV_XLEN-1:0] tgt_q;
  logic [CNT_W-1:0]    out_q;      // Requests in flight, stale ones included
  logic [CNT_W-1:0]    out_d;
  logic [CNT_W-1:0]    drop_q;     // Stale responses still to count off
  logic [CNT_W-1:0]    cnt_q;      // Buffer fill
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [`RV_XLEN-1:0] buf_pc_q    [`RV_FETCH_DEPTH];
  logic [31:0]         buf_instr_q [`RV_FETCH_DEPTH];
  logic                granted;
  logic                held;
  logic                stale_rsp;
  logic                live_rsp;
  logic                push;
  logic                pop;

  // Issue only if every live response is sure of a buffer slot
  assign instr_req_o.req   = en_q && (out_q < CNT_W'(`RV_FETCH_DEPTH)) &&
                             ((out_q - drop_q + cnt_q) < CNT_W'(`RV_FETCH_DEPTH));
  assign instr_req_o.we    = 1'b0;
  assign instr_req_o.addr  = pc_q;
  assign instr_req_o.wdata = '0;

  assign granted   = instr_req_o.req && instr_rsp_i.gnt;
  assign held      = instr_req_o.req && !instr_rsp_i.gnt;   // Must repeat next cycle
  assign stale_rsp = instr_rsp_i.rvalid && (drop_q != '0);
  assign live_rsp  = instr_rsp_i.rvalid && (drop_q == '0);
  assign push      = live_rsp && !redirect_i.valid;
  assign pop       = fetch_o.valid && id_ready_i;
  assign out_d     = out_q + CNT_W'(granted) - CNT_W'(instr_rsp_i.rvalid);

  assign fetch_o.valid = (cnt_q != '0);
  assign fetch_o.pc    = buf_pc_q[rd_ptr_q];
  assign fetch_o.instr = buf_instr_q[rd_ptr_q];

  //////////////////////////////////////////////////////////////////////
  // PC and in-flight bookkeeping
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      en_q     <= 1'b0;
      pc_q     <= '0;
      rsp_pc_q <= '0;
      pend_q   <= 1'b0;
      out_q    <= '0;
      drop_q   <= '0;
    end else begin
      out_q <= out_d;
      if (!en_q && fetch_enable_i) begin
        en_q     <= 1'b1;
        pc_q     <= boot_addr_i;
        rsp_pc_q <= boot_addr_i;
      end
      if (redirect_i.valid) begin
        drop_q   <= out_d;                 // All in flight is old path
        rsp_pc_q <= redirect_i.target;
        if (held) pend_q <= 1'b1;          // Address frozen until gnt
        else      pc_q   <= redirect_i.target;
      end else begin
        drop_q <= drop_q - CNT_W'(stale_rsp) + CNT_W'(granted && pend_q);
        if (live_rsp) rsp_pc_q <= rsp_pc_q + `RV_XLEN'(4);
        if (granted) begin
          pc_q   <= pend_q ? tgt_q : pc_q + `RV_XLEN'(4);
          pend_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (redirect_i.valid) tgt_q <= redirect_i.target;
  end

  // Prefetch buffer, flushed on redirect
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else if (redirect_i.valid) begin
      cnt_q    <= '0;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else begin
      cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
      if (push) wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      if (pop)  rd_ptr_q <= rd_ptr_q + PTR_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      buf_pc_q[wr_ptr_q]    <= rsp_pc_q;
      buf_instr_q[wr_ptr_q] <= instr_rsp_i.rdata;
    end
  end

  // Bus hold rule, also across a redirect
  a_req_stable : assert property (@(posedge clk) disable iff (!rst_ni)
    held |=> $stable(instr_req_o));

  a_out_bound : assert property (@(posedge clk) disable iff (!rst_ni)
    out_q <= CNT_W'(`RV_FETCH_DEPTH));

endmodule

/* design/rv_id_ex_stage.sv */
//////////////////////////////////////////////////////////////////////
// Decode and execute stage
// Decoder, ALU, branch decision, LSU command and writeback
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "rv_core_params.svh"

module rv_id_ex_stage (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  rv_core_pkg::fetch_t    fetch_i,
  input  logic [`RV_XLEN-1:0]    rs1_rdata_i,
  input  logic [`RV_XLEN-1:0]    rs2_rdata_i,
  input  logic                   lsu_done_i,
  input  logic [`RV_XLEN-1:0]    lsu_rdata_i,
  output logic                   id_ready_o,
  output rv_core_pkg::redirect_t redirect_o,
  output logic [`RV_REG_AW-1:0]  rs1_addr_o,
  output logic [`RV_REG_AW-1:0]  rs2_addr_o,
  output logic                   rf_we_o,
  output logic [`RV_REG_AW-1:0]  rf_waddr_o,
  output logic [`RV_XLEN-1:0]    rf_wdata_o,
  output rv_core_pkg::lsu_cmd_t  lsu_cmd_o
);

  logic [31:0]          instr;
  rv_core_pkg::opcode_e opcode;
  logic [2:0]           funct3;
  logic [`RV_XLEN-1:0]  imm_i, imm_s, imm_b, imm_u, imm_j;
  rv_core_pkg::alu_op_e alu_op;
  logic [`RV_XLEN-1:0]  op_b;
  logic [`RV_XLEN-1:0]  alu_res;
  logic                 wb_en;
  logic                 is_load, is_store, is_br, is_jal;
  logic                 legal;
  logic                 taken;
  logic                 mem_op;
  logic                 accept;

  assign instr  = fetch_i.instr;
  assign opcode = rv_core_pkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];

  assign rs1_addr_o = instr[19:15];
  assign rs2_addr_o = instr[24:20];
  assign rf_waddr_o = instr[11:7];

  // Sign-extended immediates
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op   = rv_core_pkg::ALU_ADD;
    op_b     = imm_i;
    wb_en    = 1'b0;
    is_load  = 1'b0;
    is_store = 1'b0;
    is_br    = 1'b0;
    is_jal   = 1'b0;
    legal    = 1'b1;
    case (opcode)
      rv_core_pkg::OP_LUI: begin
        alu_op = rv_core_pkg::ALU_PASSB;
        op_b   = imm_u;
        wb_en  = 1'b1;
      end
      rv_core_pkg::OP_OPIMM, rv_core_pkg::OP_OP: begin
        wb_en = 1'b1;
        if (opcode == rv_core_pkg::OP_OP) op_b = rs2_rdata_i;
        case (funct3)
          3'b000: alu_op = (opcode == rv_core_pkg::OP_OP && instr[30]) ?
                           rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
          3'b010: alu_op = rv_core_pkg::ALU_SLT;
          3'b100: alu_op = rv_core_pkg::ALU_XOR;
          3'b110: alu_op = rv_core_pkg::ALU_OR;
          3'b111: alu_op = rv_core_pkg::ALU_AND;
          default: legal = 1'b0;             // Shifts, SLTU
        endcase
        // funct7 is zero, or SUB's 0100000
        if (opcode == rv_core_pkg::OP_OP && instr[31:25] != 7'b0 &&
            !(instr[31:25] == 7'b0100000 && funct3 == 3'b000)) legal = 1'b0;
      end
      rv_core_pkg::OP_LOAD: begin
        is_load = 1'b1;
        wb_en   = 1'b1;
        legal   = (funct3 == 3'b010);        // LW only
      end
      rv_core_pkg::OP_STORE: begin
        is_store = 1'b1;
        op_b     = imm_s;
        legal    = (funct3 == 3'b010);       // SW only
      end
      rv_core_pkg::OP_BRANCH: begin
        is_br  = 1'b1;
        alu_op = rv_core_pkg::ALU_SUB;       // Zero result means equal
        op_b   = rs2_rdata_i;
        legal  = (funct3[2:1] == 2'b00);     // BEQ, BNE
      end
      rv_core_pkg::OP_JAL: begin
        is_jal = 1'b1;
        wb_en  = 1'b1;
      end
      default: legal = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // ALU and branch
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_op)
      rv_core_pkg::ALU_SUB:   alu_res = rs1_rdata_i - op_b;
      rv_core_pkg::ALU_AND:   alu_res = rs1_rdata_i & op_b;
      rv_core_pkg::ALU_OR:    alu_res = rs1_rdata_i | op_b;
      rv_core_pkg::ALU_XOR:   alu_res = rs1_rdata_i ^ op_b;
      rv_core_pkg::ALU_SLT:   alu_res = {{(`RV_XLEN-1){1'b0}},
                                         $signed(rs1_rdata_i) < $signed(op_b)};
      rv_core_pkg::ALU_PASSB: alu_res = op_b;
      default:                alu_res = rs1_rdata_i + op_b;   // ADD, address calc
    endcase
  end

  assign taken = is_br && ((alu_res == '0) ^ funct3[0]);    // funct3[0] flips to BNE

  // Stall while a load or store is out on the data bus
  assign mem_op     = fetch_i.valid && legal && (is_load || is_store);
  assign id_ready_o = !mem_op || lsu_done_i;
  assign accept     = fetch_i.valid && id_ready_o;

  assign redirect_o.valid  = accept && legal && (is_jal || taken);
  assign redirect_o.target = fetch_i.pc + (is_jal ? imm_j : imm_b);

  assign lsu_cmd_o.valid = mem_op;
  assign lsu_cmd_o.we    = is_store;
  assign lsu_cmd_o.addr  = alu_res;
  assign lsu_cmd_o.wdata = rs2_rdata_i;

  // Writeback select
  assign rf_we_o    = accept && legal && wb_en;
  assign rf_wdata_o = is_load ? lsu_rdata_i :
                      is_jal  ? fetch_i.pc + `RV_XLEN'(4) : alu_res;

  // Anything IF hands over must be in the subset
  a_legal_instr : assert property (@(posedge clk) disable iff (!rst_ni)
    accept |-> legal);

endmodule

/* design/rv_register_file.sv */
//////////////////////////////////////////////////////////////////////
// Register file with x0 hardwired to zero
// Two combinational read ports, one write port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "rv_core_params.svh"

module rv_register_file (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic [`RV_REG_AW-1:0] raddr_a_i,
  input  logic [`RV_REG_AW-1:0] raddr_b_i,
  input  logic                  we_i,
  input  logic [`RV_REG_AW-1:0] waddr_i,
  input  logic [`RV_XLEN-1:0]   wdata_i,
  output logic [`RV_XLEN-1:0]   rdata_a_o,
  output logic [`RV_XLEN-1:0]   rdata_b_o
);

  logic [`RV_XLEN-1:0] regs_q [1:`RV_NUM_REGS-1];   // No storage for x0

  // One read port, same for a and b
  function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_AW-1:0] addr);
    if (addr == '0) return '0;
    return regs_q[addr];   // Value before any same-cycle write
  endfunction

  always_comb begin
    rdata_a_o = read_port(raddr_a_i);
    rdata_b_o = read_port(raddr_b_i);
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) regs_q[i] <= '0;
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

endmodule

/* design/rv_load_store_unit.sv */
//////////////////////////////////////////////////////////////////////
// Load-store unit
// Word access on the data bus, one command at a time
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "rv_core_params.svh"

module rv_load_store_unit (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  rv_core_pkg::lsu_cmd_t lsu_cmd_i,
  input  rv_core_pkg::mem_rsp_t data_rsp_i,
  output rv_core_pkg::mem_req_t data_req_o,
  output logic                  lsu_done_o,
  output logic [`RV_XLEN-1:0]   lsu_rdata_o
);

  typedef enum logic {
    IDLE,
    WAIT_RSP
  } lsu_state_e;

  lsu_state_e state_q, state_d;

  // Command is held by ID-EX, so the request holds until gnt
  assign data_req_o.req   = (state_q == IDLE) && lsu_cmd_i.valid;
  assign data_req_o.we    = lsu_cmd_i.we;
  assign data_req_o.addr  = lsu_cmd_i.addr;
  assign data_req_o.wdata = lsu_cmd_i.wdata;

  always_comb begin
    state_d    = state_q;
    lsu_done_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (data_req_o.req && data_rsp_i.gnt) state_d = WAIT_RSP;
      end
      WAIT_RSP: begin
        if (data_rsp_i.rvalid) begin
          lsu_done_o = 1'b1;        // Releases ID-EX this cycle
          state_d    = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign lsu_rdata_o = data_rsp_i.rdata;   // Valid with done on a load

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) state_q <= IDLE;
    else         state_q <= state_d;
  end

  a_req_stable : assert property (@(posedge clk) disable iff (!rst_ni)
    data_req_o.req && !data_rsp_i.gnt |=> $stable(data_req_o));

  // Memory answers only a granted request
  a_rsp_expected : assert property (@(posedge clk) disable iff (!rst_ni)
    data_rsp_i.rvalid |-> state_q == WAIT_RSP);

endmodule

/* design/rv_core.sv */
//////////////////////////////////////////////////////////////////////
// RV32I core top level
// Fetch, decode-execute, register file and load-store unit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "rv_core_params.svh"

module rv_core (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  fetch_enable_i,
  input  logic [`RV_XLEN-1:0]   boot_addr_i,
  input  rv_core_pkg::mem_rsp_t instr_rsp_i,
  input  rv_core_pkg::mem_rsp_t data_rsp_i,
  output rv_core_pkg::mem_req_t instr_req_o,
  output rv_core_pkg::mem_req_t data_req_o
);

  rv_core_pkg::fetch_t    fetch;
  rv_core_pkg::redirect_t redirect;
  rv_core_pkg::lsu_cmd_t  lsu_cmd;
  logic                   id_ready;
  logic [`RV_REG_AW-1:0]  rs1_addr, rs2_addr, rf_waddr;
  logic [`RV_XLEN-1:0]    rs1_rdata, rs2_rdata, rf_wdata;
  logic                   rf_we;
  logic                   lsu_done;
  logic [`RV_XLEN-1:0]    lsu_rdata;

  //////////////////////////////////////////////////////////////////////
  // Fetch
  //////////////////////////////////////////////////////////////////////

  rv_if_stage if_stage_inst (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_rsp_i    ( instr_rsp_i    ),
    .redirect_i     ( redirect       ),   // Taken branch or JAL
    .id_ready_i     ( id_ready       ),
    .instr_req_o    ( instr_req_o    ),
    .fetch_o        ( fetch          )
  );

  //////////////////////////////////////////////////////////////////////
  // Decode, execute, writeback
  //////////////////////////////////////////////////////////////////////

  rv_id_ex_stage id_ex_stage_inst (
    .clk         ( clk       ),
    .rst_ni      ( rst_ni    ),
    .fetch_i     ( fetch     ),
    .rs1_rdata_i ( rs1_rdata ),
    .rs2_rdata_i ( rs2_rdata ),
    .lsu_done_i  ( lsu_done  ),
    .lsu_rdata_i ( lsu_rdata ),
    .id_ready_o  ( id_ready  ),
    .redirect_o  ( redirect  ),
    .rs1_addr_o  ( rs1_addr  ),
    .rs2_addr_o  ( rs2_addr  ),
    .rf_we_o     ( rf_we     ),
    .rf_waddr_o  ( rf_waddr  ),
    .rf_wdata_o  ( rf_wdata  ),
    .lsu_cmd_o   ( lsu_cmd   )
  );

  rv_register_file register_file_inst (
    .clk       ( clk       ),
    .rst_ni    ( rst_ni    ),
    .raddr_a_i ( rs1_addr  ),
    .raddr_b_i ( rs2_addr  ),
    .we_i      ( rf_we     ),
    .waddr_i   ( rf_waddr  ),
    .wdata_i   ( rf_wdata  ),
    .rdata_a_o ( rs1_rdata ),
    .rdata_b_o ( rs2_rdata )
  );

  //////////////////////////////////////////////////////////////////////
  // Data bus
  //////////////////////////////////////////////////////////////////////

  rv_load_store_unit load_store_unit_inst (
    .clk         ( clk        ),
    .rst_ni      ( rst_ni     ),
    .lsu_cmd_i   ( lsu_cmd    ),
    .data_rsp_i  ( data_rsp_i ),
    .data_req_o  ( data_req_o ),
    .lsu_done_o  ( lsu_done   ),   // Ends the ID-EX stall
    .lsu_rdata_o ( lsu_rdata  )
  );

endmodule

/* sim/tb_mem.sv */
//////////////////////////////////////////////////////////////////////
// Memory model for the testbench
// Shared word array, instr and data responders with random delays,
// bus hold checks and a store report for the checker
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_mem (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  rv_core_pkg::mem_req_t instr_req_i,
  input  rv_core_pkg::mem_req_t data_req_i,
  output rv_core_pkg::mem_rsp_t instr_rsp_o,
  output rv_core_pkg::mem_rsp_t data_rsp_o,
  output logic                  store_valid_o,
  output logic [31:0]           store_addr_o,
  output logic [31:0]           store_data_o,
  output int                    err_cnt_o
);

  logic [31:0] mem [0:1023];           // 4 KiB, loaded by the top module

  integer                seed = 32'he51d6c27;
  int unsigned           cycle;
  int unsigned           i_gap, d_gap;  // Cycles left before next gnt
  logic [63:0]           i_pend[$];     // {due cycle, rdata}
  logic [63:0]           d_pend[$];
  logic                  i_held, d_held;
  rv_core_pkg::mem_req_t i_prev, d_prev;

  task automatic draw_delay(output int unsigned d);
    d = $unsigned($random(seed)) % 4;
  endtask

  initial begin
    int unsigned dly;
    instr_rsp_o   = '0;
    data_rsp_o    = '0;
    store_valid_o = 1'b0;
    store_addr_o  = '0;
    store_data_o  = '0;
    err_cnt_o     = 0;
    cycle         = 0;
    i_gap         = 0;
    d_gap         = 0;
    i_held        = 1'b0;
    d_held        = 1'b0;
    forever begin
      @(negedge clk);
      cycle++;
      // Responses, in order, one per accepted request
      instr_rsp_o.rvalid = 1'b0;
      data_rsp_o.rvalid  = 1'b0;
      if (i_pend.size() > 0 && i_pend[0][63:32] <= cycle) begin
        instr_rsp_o.rvalid = 1'b1;
        instr_rsp_o.rdata  = i_pend[0][31:0];
        void'(i_pend.pop_front());
      end
      if (d_pend.size() > 0 && d_pend[0][63:32] <= cycle) begin
        data_rsp_o.rvalid = 1'b1;
        data_rsp_o.rdata  = d_pend[0][31:0];
        void'(d_pend.pop_front());
      end
      instr_rsp_o.gnt = rst_ni && (i_gap == 0);
      data_rsp_o.gnt  = rst_ni && (d_gap == 0);
      if (i_gap != 0) i_gap--;
      if (d_gap != 0) d_gap--;

      #4;  // Just before the rising edge, core outputs settled
      store_valid_o = 1'b0;
      if (i_held) begin
        assert (instr_req_i == i_prev) else begin
          $display("** Error %0t: instr request changed before gnt", $time);
          err_cnt_o++;
        end
      end
      if (d_held) begin
        assert (data_req_i == d_prev) else begin
          $display("** Error %0t: data request changed before gnt", $time);
          err_cnt_o++;
        end
      end
      i_held = instr_req_i.req && !instr_rsp_o.gnt;
      d_held = data_req_i.req && !data_rsp_o.gnt;
      i_prev = instr_req_i;
      d_prev = data_req_i;

      // Accepts
      if (instr_req_i.req && instr_rsp_o.gnt) begin
        draw_delay(dly);
        i_pend.push_back({cycle + 1 + dly, mem[instr_req_i.addr[11:2]]});
        draw_delay(i_gap);
      end
      if (data_req_i.req && data_rsp_o.gnt) begin
        draw_delay(dly);
        if (data_req_i.we) begin
          mem[data_req_i.addr[11:2]] = data_req_i.wdata;
          store_valid_o = 1'b1;
          store_addr_o  = data_req_i.addr;
          store_data_o  = data_req_i.wdata;
          d_pend.push_back({cycle + 1 + dly, 32'h0});
        end else begin
          d_pend.push_back({cycle + 1 + dly, mem[data_req_i.addr[11:2]]});
        end
        draw_delay(d_gap);
      end
    end
  end

endmodule

/* sim/tb_rv_core.sv */
//////////////////////////////////////////////////////////////////////
// Testbench top for the RV32I core
// Clock, reset, program image, ISA reference model, store checker
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_rv_core;

  localparam logic [31:0] BOOT   = 32'h0000_0100;
  localparam logic [31:0] FINISH = 32'h0000_07fc;

  logic                  clk;
  logic                  rst_ni;
  logic                  fetch_enable;
  logic [31:0]           boot_addr;
  rv_core_pkg::mem_req_t instr_req, data_req;
  rv_core_pkg::mem_rsp_t instr_rsp, data_rsp;
  logic                  st_valid;
  logic [31:0]           st_addr, st_data;
  int                    mem_errs;

  logic [31:0] ref_mem [0:1023];
  logic [31:0] exp_addr_q[$];
  logic [31:0] exp_data_q[$];
  int          err_cnt;
  int          n_instr;
  int          pc_idx;          // Next image slot
  logic        done;
  logic        first_seen;

  rv_core rv_core_inst (
    .clk            ( clk          ),
    .rst_ni         ( rst_ni       ),
    .fetch_enable_i ( fetch_enable ),
    .boot_addr_i    ( boot_addr    ),
    .instr_rsp_i    ( instr_rsp    ),
    .data_rsp_i     ( data_rsp     ),
    .instr_req_o    ( instr_req    ),
    .data_req_o     ( data_req     )
  );

  tb_mem mem_inst (
    .clk           ( clk       ),
    .rst_ni        ( rst_ni    ),
    .instr_req_i   ( instr_req ),
    .data_req_i    ( data_req  ),
    .instr_rsp_o   ( instr_rsp ),
    .data_rsp_o    ( data_rsp  ),
    .store_valid_o ( st_valid  ),
    .store_addr_o  ( st_addr   ),
    .store_data_o  ( st_data   ),
    .err_cnt_o     ( mem_errs  )
  );

  //////////////////////////////////////////////////////////////////////
  // Instruction encoders
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic put(input logic [31:0] w);
    ref_mem[BOOT[11:2] + pc_idx] = w;
    pc_idx++;
  endtask

  // Fill, array data, then the program
  task automatic load_image();
    pc_idx = 0;
    for (int i = 0; i < 1024; i++) ref_mem[i] = 32'hc0de_0000 ^ (i * 32'h0001_0004);
    ref_mem[256] = 32'd5;
    ref_mem[257] = 32'h7fff_fff0;
    ref_mem[258] = 32'hffff_fffd;
    ref_mem[259] = 32'h11;
    put(enc_i(32'h400, 0, 0, 1, 7'h13));   // x1 array base
    put(enc_i(4, 0, 0, 2, 7'h13));
    put(enc_i(0, 0, 0, 3, 7'h13));
    put(enc_i(0, 1, 2, 4, 7'h03));         // Loop: lw x4
    put(enc_r(0, 4, 3, 0, 3));             // Load-use add
    put(enc_i(4, 1, 0, 1, 7'h13));
    put(enc_i(-1, 2, 0, 2, 7'h13));
    put(enc_b(-16, 0, 2, 1));              // bne back to loop
    put(enc_i(32'h600, 0, 0, 5, 7'h13));   // x5 result base
    put(enc_s(0, 3, 5));
    put({20'h12345, 5'd6, 7'h37});         // lui
    put(enc_i(32'h678, 6, 0, 6, 7'h13));
    put(enc_s(4, 6, 5));
    put(enc_i(-1, 6, 4, 7, 7'h13));        // xori
    put(enc_s(8, 7, 5));
    put(enc_i(32'h0f0, 6, 6, 8, 7'h13));   // ori
    put(enc_i(32'h0ff, 6, 7, 9, 7'h13));   // andi
    put(enc_i(5, 7, 2, 10, 7'h13));        // slti
    put(enc_s(12, 8, 5));
    put(enc_s(16, 9, 5));
    put(enc_s(20, 10, 5));
    put(enc_r(7'h20, 3, 6, 0, 11));        // sub
    put(enc_r(0, 7, 6, 7, 12));            // and
    put(enc_r(0, 4, 11, 6, 13));           // or
    put(enc_r(0, 6, 11, 4, 14));           // xor
    put(enc_r(0, 11, 6, 2, 15));           // slt
    for (int r = 11; r <= 15; r++) put(enc_s(24 + (r - 11) * 4, r[4:0], 5));
    put(enc_i(4, 5, 2, 16, 7'h03));        // lw, used next
    put(enc_i(1, 16, 0, 17, 7'h13));
    put(enc_s(44, 17, 5));
    put(enc_b(8, 16, 17, 0));              // beq not taken
    put(enc_b(8, 16, 16, 0));              // beq taken
    put(enc_s(48, 0, 5));                  // Flushed path
    put(enc_j(12, 18));                    // jal x18
    put(enc_s(52, 0, 5));
    put(enc_s(56, 0, 5));
    put(enc_s(60, 18, 5));                 // Link value
    put(enc_i(1, 0, 0, 19, 7'h13));
    put(enc_s(32'h1fc, 19, 5));            // Finish store
    put(enc_j(0, 0));                      // Spin
    for (int i = 0; i < 1024; i++) mem_inst.mem[i] = ref_mem[i];
  endtask

  //////////////////////////////////////////////////////////////////////
  // ISA reference model, fills the expected store list
  //////////////////////////////////////////////////////////////////////

  function automatic int run_model();
    logic [31:0] x [32];
    logic [31:0] m [0:1023];
    logic [31:0] pc, ins, a, b, res, imm_i, imm_s, imm_b, imm_j, ea;
    logic [2:0]  f3;
    int          cnt;
    for (int i = 0; i < 32; i++) x[i] = '0;
    for (int i = 0; i < 1024; i++) m[i] = ref_mem[i];
    pc  = BOOT;
    cnt = 0;
    while (cnt < 2000) begin
      ins   = m[pc[11:2]];
      f3    = ins[14:12];
      a     = x[ins[19:15]];
      b     = x[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      cnt++;
      case (ins[6:0])
        7'h37: begin
          x[ins[11:7]] = {ins[31:12], 12'h0};
          pc += 4;
        end
        7'h13, 7'h33: begin
          if (ins[6:0] == 7'h13) b = imm_i;
          case (f3)
            3'd0: res = (ins[5] && ins[30]) ? a - b : a + b;
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd4: res = a ^ b;
            3'd6: res = a | b;
            default: res = a & b;
          endcase
          x[ins[11:7]] = res;
          pc += 4;
        end
        7'h03: begin
          ea = a + imm_i;
          x[ins[11:7]] = m[ea[11:2]];
          pc += 4;
        end
        7'h23: begin
          ea = a + imm_s;
          m[ea[11:2]] = b;
          exp_addr_q.push_back(ea);
          exp_data_q.push_back(b);
          if (ea == FINISH) return cnt;
          pc += 4;
        end
        7'h63: pc = ((a == b) ^ f3[0]) ? pc + imm_b : pc + 4;
        7'h6f: begin
          x[ins[11:7]] = pc + 4;
          pc += imm_j;
        end
        default: begin
          $display("Reference model hit an unknown instruction at %h", pc);
          return cnt;
        end
      endcase
      x[0] = '0;
    end
    return cnt;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Clock, checks, run control
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Fetch must wait for reset and enable, then start at boot
  always @(negedge clk) begin
    if (!rst_ni || !fetch_enable) begin
      assert (!instr_req.req) else begin
        $display("** Error %0t: instr req high before fetch enable", $time);
        err_cnt++;
      end
    end
    if (instr_req.req && !first_seen) begin
      first_seen = 1'b1;
      assert (instr_req.addr == boot_addr) else begin
        $display("** Error %0t: first fetch at %h, expected %h", $time,
                 instr_req.addr, boot_addr);
        err_cnt++;
      end
    end
  end

  // Store checker, in program order
  always @(posedge clk) begin
    if (st_valid && !done) begin
      if (exp_addr_q.size() == 0) begin
        $display("** Error %0t: store to %h beyond the expected list", $time, st_addr);
        err_cnt++;
      end else begin
        assert (st_addr == exp_addr_q[0] && st_data == exp_data_q[0]) else begin
          $display("** Error %0t: store %h <= %h, expected %h <= %h", $time,
                   st_addr, st_data, exp_addr_q[0], exp_data_q[0]);
          err_cnt++;
        end
        void'(exp_addr_q.pop_front());
        void'(exp_data_q.pop_front());
      end
      if (st_addr == FINISH) done = 1'b1;
    end
  end

  initial begin
    int cycles;
    int limit;
    rst_ni       = 1'b0;
    fetch_enable = 1'b0;
    boot_addr    = BOOT;
    err_cnt      = 0;
    done         = 1'b0;
    first_seen   = 1'b0;
    cycles       = 0;
    load_image();
    n_instr = run_model();
    limit   = 20 * n_instr;
    repeat (16) @(negedge clk);
    rst_ni = 1'b1;
    repeat (4) @(negedge clk);
    fetch_enable = 1'b1;
    while (!done && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      $display("Timeout: no finish store within %0d cycles", limit);
    end else begin
      assert (exp_addr_q.size() == 0) else begin
        $display("** Error %0t: %0d expected stores missing", $time, exp_addr_q.size());
        err_cnt++;
      end
    end
    $display("Errors: %0d checker, %0d bus, %0d instructions in model",
             err_cnt, mem_errs, n_instr);
    if (done && err_cnt == 0 && mem_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+design
design/rv_core_pkg.sv
design/rv_if_stage.sv
design/rv_id_ex_stage.sv
design/rv_register_file.sv
design/rv_load_store_unit.sv
design/rv_core.sv
sim/tb_mem.sv
sim/tb_rv_core.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_rv_core -o vsim
	out="$$(obj_dir/vsim)"; echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir
